// ==== verilog/vrc6_macros.svh ====
// ==================================================
// VRC6 constants
// register selectors, IRQ reloads, channel limits
// ==================================================
`ifndef VRC6_MACROS_SVH
`define VRC6_MACROS_SVH

// register selectors are {A15..A12, A1, A0} after the mapper 26 swap
`define VRC6_ADDR_PRG8       6'b1000??
`define VRC6_ADDR_SQ1_CTRL   6'b100100
`define VRC6_ADDR_SQ1_LO     6'b100101
`define VRC6_ADDR_SQ1_HI     6'b100110
`define VRC6_ADDR_SQ2_CTRL   6'b101000
`define VRC6_ADDR_SQ2_LO     6'b101001
`define VRC6_ADDR_SQ2_HI     6'b101010
`define VRC6_ADDR_SAW_RATE   6'b101100
`define VRC6_ADDR_SAW_LO     6'b101101
`define VRC6_ADDR_SAW_HI     6'b101110
`define VRC6_ADDR_MIRROR     6'b101111
`define VRC6_ADDR_PRGC       6'b1100??
`define VRC6_ADDR_CHR_LO     6'b1101??
`define VRC6_ADDR_CHR_HI     6'b1110??
`define VRC6_ADDR_IRQ_LATCH  6'b111100
`define VRC6_ADDR_IRQ_CTRL   6'b111101
`define VRC6_ADDR_IRQ_ACK    6'b111110

`define VRC6_PRG_FIXED       6'b111111  // bank at $E000
`define VRC6_WRAM_PAGE       3'b011     // $6000-$7FFF

`define VRC6_MIRROR_VERT     2'd0
`define VRC6_MIRROR_HORZ     2'd1
`define VRC6_MIRROR_ONE_A    2'd2
`define VRC6_MIRROR_ONE_B    2'd3

`define VRC6_PRESCALE_LONG   7'd113
`define VRC6_PRESCALE_SHORT  7'd112
`define VRC6_IRQ_WRAP        8'd255

`define VRC6_CH_EN_BIT       7          // enable bit in the $x002 writes
`define VRC6_SAW_STEPS       3'd6
`define VRC6_SND_MAX         61

`endif

// ==== verilog/vrc6_pkg.sv ====
// ==================================================
// VRC6 shared types
// ==================================================
`include "vrc6_macros.svh"

package vrc6_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [13:0] ppu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    typedef logic [5:0]  prg_bank_t;   // PRG address 18:13
    typedef logic [7:0]  chr_bank_t;   // one 1 KB page
    typedef logic [8:0]  chr_page_t;   // CHR address 18:10
    typedef logic [6:0]  chr_mask_t;
    typedef logic [1:0]  mirror_t;

    typedef logic [11:0] freq_t;
    typedef logic [3:0]  vol_t;
    typedef logic [5:0]  saw_rate_t;
    typedef logic [4:0]  saw_out_t;

    // wide enough for two pulses plus the saw
    typedef logic [$clog2(`VRC6_SND_MAX + 1) - 1:0] snd_mix_t;

    typedef logic [7:0]  irq_count_t;

    typedef enum logic {
        IRQ_SCANLINE = 1'b0,
        IRQ_CYCLE    = 1'b1
    } irq_mode_t;

endpackage

// ==== verilog/vrc6_regs.sv ====
// ==================================================
// VRC6 register decoder
// CPU write strobes plus bank and mirror registers
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_regs
    import vrc6_pkg::*;
(
    input  logic            clk20,
    input  logic            reset,
    input  logic            ce,
    input  logic            nesprg_we,
    input  cpu_addr_t       prgain,
    input  cpu_data_t       nesprgdin,
    input  logic            mapper26,
    output prg_bank_t       prg_bank8,
    output prg_bank_t       prg_bank_c,
    output chr_bank_t [7:0] chr_bank,
    output mirror_t         mirror,
    output logic            irq_latch_wr,
    output logic            irq_ctrl_wr,
    output logic            irq_ack_wr,
    output logic            sq1_ctrl_wr,
    output logic            sq1_lo_wr,
    output logic            sq1_hi_wr,
    output logic            sq2_ctrl_wr,
    output logic            sq2_lo_wr,
    output logic            sq2_hi_wr,
    output logic            saw_rate_wr,
    output logic            saw_lo_wr,
    output logic            saw_hi_wr,
    output cpu_data_t       wr_data
);
    cpu_addr_t  ain;
    logic [5:0] reg_sel;
    logic [2:0] chr_idx;
    logic       cpu_wr;
    logic       prg8_wr;
    logic       prgc_wr;
    logic       mirror_wr;
    logic       chr_wr;

    // mapper 26 has A0 and A1 swapped on the board
    assign ain     = mapper26 ? {prgain[15:2], prgain[0], prgain[1]} : prgain;
    assign reg_sel = {ain[15:12], ain[1:0]};
    assign chr_idx = {ain[13], ain[1:0]};  // D00x -> 0..3, E00x -> 4..7
    assign cpu_wr  = ce & nesprg_we;
    assign wr_data = nesprgdin;

    always_comb begin
        prg8_wr      = 1'b0;
        prgc_wr      = 1'b0;
        mirror_wr    = 1'b0;
        chr_wr       = 1'b0;
        irq_latch_wr = 1'b0;
        irq_ctrl_wr  = 1'b0;
        irq_ack_wr   = 1'b0;
        sq1_ctrl_wr  = 1'b0;
        sq1_lo_wr    = 1'b0;
        sq1_hi_wr    = 1'b0;
        sq2_ctrl_wr  = 1'b0;
        sq2_lo_wr    = 1'b0;
        sq2_hi_wr    = 1'b0;
        saw_rate_wr  = 1'b0;
        saw_lo_wr    = 1'b0;
        saw_hi_wr    = 1'b0;
        if (cpu_wr) begin
            casez (reg_sel)
                `VRC6_ADDR_PRG8:      prg8_wr      = 1'b1;
                `VRC6_ADDR_SQ1_CTRL:  sq1_ctrl_wr  = 1'b1;
                `VRC6_ADDR_SQ1_LO:    sq1_lo_wr    = 1'b1;
                `VRC6_ADDR_SQ1_HI:    sq1_hi_wr    = 1'b1;
                `VRC6_ADDR_SQ2_CTRL:  sq2_ctrl_wr  = 1'b1;
                `VRC6_ADDR_SQ2_LO:    sq2_lo_wr    = 1'b1;
                `VRC6_ADDR_SQ2_HI:    sq2_hi_wr    = 1'b1;
                `VRC6_ADDR_SAW_RATE:  saw_rate_wr  = 1'b1;
                `VRC6_ADDR_SAW_LO:    saw_lo_wr    = 1'b1;
                `VRC6_ADDR_SAW_HI:    saw_hi_wr    = 1'b1;
                `VRC6_ADDR_MIRROR:    mirror_wr    = 1'b1;
                `VRC6_ADDR_PRGC:      prgc_wr      = 1'b1;
                `VRC6_ADDR_CHR_LO,
                `VRC6_ADDR_CHR_HI:    chr_wr       = 1'b1;
                `VRC6_ADDR_IRQ_LATCH: irq_latch_wr = 1'b1;
                `VRC6_ADDR_IRQ_CTRL:  irq_ctrl_wr  = 1'b1;
                `VRC6_ADDR_IRQ_ACK:   irq_ack_wr   = 1'b1;
                default:              ;
            endcase
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            prg_bank8  <= '0;
            prg_bank_c <= '0;
            chr_bank   <= '0;
            mirror     <= '0;
        end else begin
            if (prg8_wr)
                prg_bank8 <= {1'b0, wr_data[4:0]};  // 16 KB bank, A13 added later
            if (prgc_wr)
                prg_bank_c <= wr_data[5:0];
            if (mirror_wr)
                mirror <= wr_data[3:2];
            if (chr_wr)
                chr_bank[chr_idx] <= wr_data;
        end
    end

endmodule

// ==== verilog/vrc6_bank_map.sv ====
// ==================================================
// VRC6 bank map
// PRG/CHR translation, mirroring, RAM enables
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_bank_map
    import vrc6_pkg::*;
(
    input  cpu_addr_t       prgain,
    input  ppu_addr_t       chrain,
    input  logic            neschr_rd,
    input  logic            neschr_wr,
    input  logic            nesprg_we,
    input  logic            m2_n,
    input  logic            cfg_boot,
    input  prg_bank_t       cfg_prgmask,
    input  chr_mask_t       cfg_chrmask,
    input  logic            cfg_chrram,
    input  prg_bank_t       prg_bank8,
    input  prg_bank_t       prg_bank_c,
    input  chr_bank_t [7:0] chr_bank,
    input  mirror_t         mirror,
    output prg_bank_t       ramprgaout,
    output chr_page_t       ramchraout,
    output logic            ciram_ce,
    output logic            chrram_we,
    output logic            chrram_oe,
    output logic            wram_we,
    output logic            wram_oe,
    output logic            prgram_oe,
    output logic            nesprg_oe
);
    prg_bank_t prg_bank;
    chr_bank_t chr_sel;
    logic      nt_a10;
    logic      wram_sel;

    always_comb begin
        casez (prgain[15:13])
            3'b0??:  prg_bank = '0;                           // below $8000
            3'b10?:  prg_bank = {prg_bank8[4:0], prgain[13]}; // $8000-$BFFF
            3'b110:  prg_bank = prg_bank_c;                   // $C000-$DFFF
            default: prg_bank = `VRC6_PRG_FIXED;
        endcase
    end

    assign ramprgaout = prg_bank & cfg_prgmask;

    assign chr_sel = chr_bank[chrain[12:10]];

    // nametable page select
    always_comb begin
        case (mirror)
            `VRC6_MIRROR_VERT:  nt_a10 = chrain[10];
            `VRC6_MIRROR_HORZ:  nt_a10 = chrain[11];
            `VRC6_MIRROR_ONE_A: nt_a10 = 1'b0;
            default:            nt_a10 = 1'b1;
        endcase
    end

    assign ramchraout[8:2] = {1'b0, chr_sel[7:2]} & cfg_chrmask;
    assign ramchraout[1]   = chr_sel[1];
    assign ramchraout[0]   = chrain[13] ? nt_a10 : chr_sel[0];

    assign ciram_ce  = chrain[13];
    assign chrram_we = neschr_wr & ~chrain[13] & cfg_chrram;
    assign chrram_oe = neschr_rd & ~chrain[13];

    assign wram_sel  = m2_n & (prgain[15:13] == `VRC6_WRAM_PAGE);
    assign wram_we   = wram_sel & nesprg_we;
    assign wram_oe   = wram_sel & ~nesprg_we;
    assign prgram_oe = ~cfg_boot & m2_n & ~nesprg_we & prgain[15];
    assign nesprg_oe = wram_oe | prgram_oe;

endmodule

// ==== verilog/vrc6_irq.sv ====
// ==================================================
// VRC6 IRQ counter
// CPU-cycle and scanline modes, latch reload on wrap
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_irq
    import vrc6_pkg::*;
(
    input  logic      clk20,
    input  logic      reset,
    input  logic      ce,
    input  logic      irq_latch_wr,
    input  logic      irq_ctrl_wr,
    input  logic      irq_ack_wr,
    input  cpu_data_t wr_data,
    output logic      irq
);
    irq_count_t latch;
    irq_count_t count;
    irq_mode_t  mode;
    logic       ack_en;    // A flag, restored into the enable on ack
    logic       irq_en;
    logic       timeout;
    logic [6:0] prescale;
    logic [1:0] line;      // phase in the 114/114/113 sequence
    logic       tick;
    logic       count_step;
    logic       wrap;

    assign tick       = ce & irq_en;
    assign count_step = (mode == IRQ_CYCLE) | (prescale == 7'd0);
    assign wrap       = (count == `VRC6_IRQ_WRAP);

    always_ff @(posedge clk20) begin
        if (irq_latch_wr)
            latch <= wr_data;
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            mode     <= IRQ_SCANLINE;
            ack_en   <= 1'b0;
            irq_en   <= 1'b0;
            timeout  <= 1'b0;
            count    <= '0;
            prescale <= '0;
            line     <= '0;
        end else begin
            if (irq_ctrl_wr) begin
                mode     <= irq_mode_t'(wr_data[2]);
                ack_en   <= wr_data[0];
                irq_en   <= wr_data[1];
                count    <= latch;
                prescale <= `VRC6_PRESCALE_LONG;
                line     <= 2'd1;  // this load is the first long line
            end else begin
                if (irq_ack_wr)
                    irq_en <= ack_en;
                if (tick) begin
                    if (prescale != 7'd0) begin
                        prescale <= prescale - 7'd1;
                    end else begin
                        prescale <= line[1] ? `VRC6_PRESCALE_SHORT : `VRC6_PRESCALE_LONG;
                        line     <= line[1] ? 2'd0 : line + 2'd1;
                    end
                    if (count_step)
                        count <= wrap ? latch : count + 8'd1;
                end
            end

            if (irq_ctrl_wr | irq_ack_wr)
                timeout <= 1'b0;
            else if (tick & count_step & wrap)
                timeout <= 1'b1;  // overflow
        end
    end

    assign irq = timeout & irq_en;

endmodule

// ==== verilog/vrc6_pulse.sv ====
// ==================================================
// VRC6 pulse channel
// period divider, 16-step duty and digital mode
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_pulse
    import vrc6_pkg::*;
(
    input  logic      clk20,
    input  logic      reset,
    input  logic      ce,
    input  logic      ctrl_wr,
    input  logic      freq_lo_wr,
    input  logic      freq_hi_wr,
    input  cpu_data_t wr_data,
    output vol_t      level
);
    logic       digital;  // constant volume, duty ignored
    logic [2:0] duty;
    vol_t       volume;
    freq_t      freq;
    logic       enable;
    freq_t      divider;
    logic [3:0] step;

    always_ff @(posedge clk20) begin
        if (ctrl_wr) begin
            digital <= wr_data[7];
            duty    <= wr_data[6:4];
            volume  <= wr_data[3:0];
        end
        if (freq_lo_wr)
            freq[7:0] <= wr_data;
        if (freq_hi_wr)
            freq[11:8] <= wr_data[3:0];
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable  <= 1'b0;
            divider <= '0;
            step    <= '0;
        end else begin
            if (freq_hi_wr)
                enable <= wr_data[`VRC6_CH_EN_BIT];
            if (ce & enable) begin
                if (divider != '0) begin
                    divider <= divider - 12'd1;
                end else begin
                    divider <= freq;
                    step    <= step + 4'd1;  // wraps after 16 steps
                end
            end
        end
    end

    assign level = (enable & (digital | (step <= {1'b0, duty}))) ? volume : '0;

endmodule

// ==== verilog/vrc6_saw.sv ====
// ==================================================
// VRC6 sawtooth channel
// seven-step accumulator, rate added per step
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_saw
    import vrc6_pkg::*;
(
    input  logic      clk20,
    input  logic      reset,
    input  logic      ce,
    input  logic      rate_wr,
    input  logic      freq_lo_wr,
    input  logic      freq_hi_wr,
    input  cpu_data_t wr_data,
    output saw_out_t  level
);
    saw_rate_t   rate;
    freq_t       freq;
    logic        enable;
    logic [12:0] divider;  // counts twice the period
    logic [2:0]  step;
    logic [7:0]  acc;

    always_ff @(posedge clk20) begin
        if (rate_wr)
            rate <= wr_data[5:0];
        if (freq_lo_wr)
            freq[7:0] <= wr_data;
        if (freq_hi_wr)
            freq[11:8] <= wr_data[3:0];
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            enable  <= 1'b0;
            divider <= '0;
            step    <= '0;
            acc     <= '0;
        end else begin
            if (freq_hi_wr)
                enable <= wr_data[`VRC6_CH_EN_BIT];
            if (ce & enable) begin
                if (divider != '0) begin
                    divider <= divider - 13'd1;
                end else begin
                    divider <= {freq, 1'b1};
                    if (step == `VRC6_SAW_STEPS) begin
                        step <= '0;
                        acc  <= '0;  // end of ramp
                    end else begin
                        step <= step + 3'd1;
                        acc  <= acc + {2'b00, rate};
                    end
                end
            end
        end
    end

    assign level = enable ? acc[7:3] : '0;

endmodule

// ==== verilog/vrc6_mapper.sv ====
// ==================================================
// VRC6 mapper top level
// register decode, banking, IRQ and expansion sound
// ==================================================
`timescale 1ns/1ps

module vrc6_mapper
    import vrc6_pkg::*;
(
    input  logic      clk20,
    input  logic      reset,
    input  logic      ce,
    input  logic      nesprg_we,
    input  cpu_addr_t prgain,
    input  cpu_data_t nesprgdin,
    input  ppu_addr_t chrain,
    input  logic      neschr_rd,
    input  logic      neschr_wr,
    input  logic      m2_n,
    input  logic      cfg_boot,
    input  prg_bank_t cfg_prgmask,
    input  chr_mask_t cfg_chrmask,
    input  logic      cfg_chrram,
    input  logic      mapper26,
    output prg_bank_t ramprgaout,
    output chr_page_t ramchraout,
    output logic      ciram_ce,
    output logic      chrram_we,
    output logic      chrram_oe,
    output logic      wram_we,
    output logic      wram_oe,
    output logic      prgram_oe,
    output logic      nesprg_oe,
    output logic      irq,
    output logic [15:0] snd_level
);
    prg_bank_t       prg_bank8;
    prg_bank_t       prg_bank_c;
    chr_bank_t [7:0] chr_bank;
    mirror_t         mirror;
    cpu_data_t       wr_data;

    logic irq_latch_wr;
    logic irq_ctrl_wr;
    logic irq_ack_wr;
    logic sq1_ctrl_wr;
    logic sq1_lo_wr;
    logic sq1_hi_wr;
    logic sq2_ctrl_wr;
    logic sq2_lo_wr;
    logic sq2_hi_wr;
    logic saw_rate_wr;
    logic saw_lo_wr;
    logic saw_hi_wr;

    vol_t     sq1_level;
    vol_t     sq2_level;
    saw_out_t saw_level;
    snd_mix_t snd_mix;

    vrc6_regs regs (
        .clk20        (clk20),
        .reset        (reset),
        .ce           (ce),
        .nesprg_we    (nesprg_we),
        .prgain       (prgain),
        .nesprgdin    (nesprgdin),
        .mapper26     (mapper26),
        .prg_bank8    (prg_bank8),
        .prg_bank_c   (prg_bank_c),
        .chr_bank     (chr_bank),
        .mirror       (mirror),
        .irq_latch_wr (irq_latch_wr),
        .irq_ctrl_wr  (irq_ctrl_wr),
        .irq_ack_wr   (irq_ack_wr),
        .sq1_ctrl_wr  (sq1_ctrl_wr),
        .sq1_lo_wr    (sq1_lo_wr),
        .sq1_hi_wr    (sq1_hi_wr),
        .sq2_ctrl_wr  (sq2_ctrl_wr),
        .sq2_lo_wr    (sq2_lo_wr),
        .sq2_hi_wr    (sq2_hi_wr),
        .saw_rate_wr  (saw_rate_wr),
        .saw_lo_wr    (saw_lo_wr),
        .saw_hi_wr    (saw_hi_wr),
        .wr_data      (wr_data)
    );

    vrc6_bank_map bank_map (
        .prgain      (prgain),
        .chrain      (chrain),
        .neschr_rd   (neschr_rd),
        .neschr_wr   (neschr_wr),
        .nesprg_we   (nesprg_we),
        .m2_n        (m2_n),
        .cfg_boot    (cfg_boot),
        .cfg_prgmask (cfg_prgmask),
        .cfg_chrmask (cfg_chrmask),
        .cfg_chrram  (cfg_chrram),
        .prg_bank8   (prg_bank8),
        .prg_bank_c  (prg_bank_c),
        .chr_bank    (chr_bank),
        .mirror      (mirror),
        .ramprgaout  (ramprgaout),
        .ramchraout  (ramchraout),
        .ciram_ce    (ciram_ce),
        .chrram_we   (chrram_we),
        .chrram_oe   (chrram_oe),
        .wram_we     (wram_we),
        .wram_oe     (wram_oe),
        .prgram_oe   (prgram_oe),
        .nesprg_oe   (nesprg_oe)
    );

    vrc6_irq irq_unit (
        .clk20        (clk20),
        .reset        (reset),
        .ce           (ce),
        .irq_latch_wr (irq_latch_wr),
        .irq_ctrl_wr  (irq_ctrl_wr),
        .irq_ack_wr   (irq_ack_wr),
        .wr_data      (wr_data),
        .irq          (irq)
    );

    vrc6_pulse pulse1 (
        .clk20      (clk20),
        .reset      (reset),
        .ce         (ce),
        .ctrl_wr    (sq1_ctrl_wr),
        .freq_lo_wr (sq1_lo_wr),
        .freq_hi_wr (sq1_hi_wr),
        .wr_data    (wr_data),
        .level      (sq1_level)
    );

    vrc6_pulse pulse2 (
        .clk20      (clk20),
        .reset      (reset),
        .ce         (ce),
        .ctrl_wr    (sq2_ctrl_wr),
        .freq_lo_wr (sq2_lo_wr),
        .freq_hi_wr (sq2_hi_wr),
        .wr_data    (wr_data),
        .level      (sq2_level)
    );

    vrc6_saw saw (
        .clk20      (clk20),
        .reset      (reset),
        .ce         (ce),
        .rate_wr    (saw_rate_wr),
        .freq_lo_wr (saw_lo_wr),
        .freq_hi_wr (saw_hi_wr),
        .wr_data    (wr_data),
        .level      (saw_level)
    );

    // 15 + 15 + 31 at most
    assign snd_mix   = {2'b00, sq1_level} + {2'b00, sq2_level} + {1'b0, saw_level};
    assign snd_level = {10'd0, snd_mix};

endmodule

// ==== test/vrc6_tb_clock.sv ====
// ==================================================
// VRC6 testbench clock
// 20 ns clock, reset held for 10 cycles
// ==================================================
`timescale 1ns/1ps

module vrc6_tb_clock (
    output logic clk20,
    output logic reset
);
    initial clk20 = 1'b0;
    always #10 clk20 = ~clk20;

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk20);
        @(negedge clk20);
        reset = 1'b0;  // released away from the active edge
    end

endmodule

// ==== test/vrc6_asserts.sv ====
// ==================================================
// VRC6 assertions
// IRQ gating, read enables, sound range
// ==================================================
`timescale 1ns/1ps
`include "vrc6_macros.svh"

module vrc6_asserts (
    input logic        clk20,
    input logic        reset,
    input logic        irq,
    input logic        irq_en,
    input logic        wram_oe,
    input logic        prgram_oe,
    input logic [15:0] snd_level
);
    int fail_count = 0;

    // a stale timeout must not show up when the enable comes back
    irq_needs_enable: assert property (@(posedge clk20) disable iff (reset)
        irq |-> irq_en && $past(irq_en))
        else begin
            $error("irq high while the IRQ enable is low or just set");
            fail_count++;
        end

    oe_exclusive: assert property (@(posedge clk20) disable iff (reset)
        !(wram_oe && prgram_oe))
        else begin
            $error("wram_oe and prgram_oe both high");
            fail_count++;
        end

    snd_in_range: assert property (@(posedge clk20) disable iff (reset)
        snd_level <= `VRC6_SND_MAX)
        else begin
            $error("snd_level above the mixer maximum");
            fail_count++;
        end

endmodule

// irq_en lives inside the IRQ unit
bind vrc6_mapper vrc6_asserts chk0 (
    .clk20     (clk20),
    .reset     (reset),
    .irq       (irq),
    .irq_en    (irq_unit.irq_en),
    .wram_oe   (wram_oe),
    .prgram_oe (prgram_oe),
    .snd_level (snd_level)
);

// ==== test/vrc6_tb.sv ====
// ==================================================
// VRC6 mapper testbench
// table of writes and checks, applied in a loop
// ==================================================
`timescale 1ns/1ps

module vrc6_tb
    import vrc6_pkg::*;
;
    localparam int K_WR = 0, K_PRG = 1, K_CHR = 2, K_NT = 3, K_OE = 4;
    localparam int K_MAP = 5, K_IRQ = 6, K_SND = 7, K_DUTY = 8, K_PEAK = 9;

    logic clk20, reset, ce, nesprg_we, neschr_rd, neschr_wr, m2_n;
    logic cfg_boot, cfg_chrram, mapper26;
    cpu_addr_t prgain;
    cpu_data_t nesprgdin;
    ppu_addr_t chrain;
    prg_bank_t cfg_prgmask, ramprgaout;
    chr_mask_t cfg_chrmask;
    chr_page_t ramchraout;
    logic ciram_ce, chrram_we, chrram_oe, wram_we, wram_oe, prgram_oe, nesprg_oe, irq;
    logic [15:0] snd_level;

    string t_name[$];
    int    t_kind[$], t_addr[$], t_data[$], t_ticks[$], t_exp[$];
    logic [31:0] seed = 32'hbe129aeb;
    int limit = 1000000;
    int cycles = 0;

    vrc6_tb_clock clkgen (.clk20(clk20), .reset(reset));

    vrc6_mapper dut0 (
        .clk20(clk20), .reset(reset), .ce(ce), .nesprg_we(nesprg_we),
        .prgain(prgain), .nesprgdin(nesprgdin), .chrain(chrain),
        .neschr_rd(neschr_rd), .neschr_wr(neschr_wr), .m2_n(m2_n),
        .cfg_boot(cfg_boot), .cfg_prgmask(cfg_prgmask), .cfg_chrmask(cfg_chrmask),
        .cfg_chrram(cfg_chrram), .mapper26(mapper26), .ramprgaout(ramprgaout),
        .ramchraout(ramchraout), .ciram_ce(ciram_ce), .chrram_we(chrram_we),
        .chrram_oe(chrram_oe), .wram_we(wram_we), .wram_oe(wram_oe),
        .prgram_oe(prgram_oe), .nesprg_oe(nesprg_oe), .irq(irq), .snd_level(snd_level)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic add_step(string name, int kind, int addr, int data, int ticks, int exp);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_ticks.push_back(ticks);
        t_exp.push_back(exp);
    endtask

    task automatic report_mismatch(string name, int exp, int act);
        $display("ERROR %s expected %0h actual %0h", name, exp, act);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_prg(string name, prg_bank_t exp, prg_bank_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_chr(string name, chr_page_t exp, chr_page_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_snd(string name, snd_mix_t exp, snd_mix_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    // page is the bank register, mask covers all but the low two page bits
    function automatic chr_page_t chr_expect(chr_bank_t c);
        chr_page_t page;
        page = {1'b0, c};
        return page & {cfg_chrmask, 2'b11};
    endfunction

    task automatic build_table();
        cpu_data_t b8, bc, c, lat;
        int a, k, m, rate, duty;
        b8 = lcg_next();
        bc = lcg_next();
        add_step("prg_w8", K_WR, 16'h8000, b8, 1, 0);
        add_step("prg_wc", K_WR, 16'hC000, bc, 1, 0);
        add_step("prg_8000", K_PRG, 16'h8123, 0, 1, {b8[4:0], 1'b0} & cfg_prgmask);
        add_step("prg_a000", K_PRG, 16'hA456, 0, 1, {b8[4:0], 1'b1} & cfg_prgmask);
        add_step("prg_c000", K_PRG, 16'hC789, 0, 1, bc[5:0] & cfg_prgmask);
        add_step("prg_e000", K_PRG, 16'hE000, 0, 1, 6'h3f & cfg_prgmask);
        // data is nesprg_we, expected {wram_we, wram_oe, prgram_oe}
        add_step("oe_wram", K_OE, 16'h6000, 0, 1, 3'b010);
        add_step("oe_wram_wr", K_OE, 16'h6000, 1, 1, 3'b100);
        add_step("oe_prg", K_OE, 16'h8000, 0, 1, 3'b001);
        add_step("oe_low", K_OE, 16'h2000, 0, 1, 3'b000);
        for (m = 0; m < 2; m++) begin
            add_step("map26", K_MAP, 0, m, 1, 0);
            for (k = 0; k < 8; k++) begin
                c = lcg_next();
                a = (k < 4) ? 16'hD000 : 16'hE000;
                // board swaps A0 and A1 on mapper 26
                a = a | (m ? {k[0], k[1]} : k[1:0]);
                add_step("chr_w", K_WR, a, c, 1, 0);
                add_step("chr_slot", K_CHR, k << 10, 0, 1, chr_expect(c));
            end
        end
        add_step("map24", K_MAP, 0, 0, 1, 0);
        for (m = 0; m < 4; m++) begin
            add_step("mirror_w", K_WR, 16'hB003, m << 2, 1, 0);
            add_step("nt_a10", K_NT, 14'h2400, 0, 1, (m == 0) ? 1 : (m == 3));
            add_step("nt_a11", K_NT, 14'h2800, 0, 1, (m == 1) || (m == 3));
        end
        lat = 8'd128 + (lcg_next() & 32'h7f);
        add_step("irq_latch", K_WR, 16'hF000, lat, 1, 0);
        add_step("irq_ctrl", K_WR, 16'hF001, 8'h06, 1, 0);  // enable, cycle mode, A clear
        add_step("irq_before", K_IRQ, 0, 0, 255 - lat, 0);
        add_step("irq_fire", K_IRQ, 0, 0, 1, 1);
        add_step("irq_ack", K_WR, 16'hF002, 0, 1, 0);
        add_step("irq_acked", K_IRQ, 0, 0, 20, 0);
        add_step("line_latch", K_WR, 16'hF000, 8'hff, 1, 0);
        add_step("line_ctrl", K_WR, 16'hF001, 8'h02, 1, 0);
        add_step("line_before", K_IRQ, 0, 0, 113, 0);
        add_step("line_fire", K_IRQ, 0, 0, 1, 1);
        add_step("line_ack", K_WR, 16'hF002, 0, 1, 0);
        add_step("line_acked", K_IRQ, 0, 0, 4, 0);
        k = 1 + lcg_next() % 15;  // nonzero volume
        add_step("sq1_lo", K_WR, 16'h9001, 0, 1, 0);
        add_step("sq1_dig", K_WR, 16'h9000, 8'h80 | k, 1, 0);
        add_step("sq1_on", K_WR, 16'h9002, 8'h80, 1, 0);
        add_step("sq1_level", K_SND, 0, 0, 2, k);
        duty = lcg_next() & 32'h7;
        add_step("sq1_duty_w", K_WR, 16'h9000, (duty << 4) | 8'h0f, 1, 0);
        add_step("sq1_duty", K_DUTY, 0, 0, 16, duty + 1);
        add_step("sq1_off", K_WR, 16'h9002, 0, 1, 0);
        add_step("sq1_quiet", K_SND, 0, 0, 2, 0);
        rate = 1 + lcg_next() % 42;  // ramp stays below 256
        add_step("saw_rate", K_WR, 16'hB000, rate, 1, 0);
        add_step("saw_lo", K_WR, 16'hB001, 0, 1, 0);
        add_step("saw_on", K_WR, 16'hB002, 8'h80, 1, 0);
        add_step("saw_peak", K_PEAK, 0, 0, 40, (6 * rate) >> 3);
        add_step("saw_off", K_WR, 16'hB002, 0, 1, 0);
        add_step("all_off", K_SND, 0, 0, 4, 0);
    endtask

    always @(posedge clk20) begin
        cycles++;
        if (cycles > limit) begin
            $display("ERROR timeout, run passed %0d cycles without finishing", limit);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    always @(negedge clk20) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("ERROR an assertion in the bound checker failed");
            $display("** FAIL **");
            $fatal(1);
        end
    end

    initial begin
        int i, cnt, peak;
        ce = 1'b1;
        nesprg_we = 1'b0;
        nesprgdin = '0;
        prgain = '0;
        chrain = '0;
        neschr_rd = 1'b1;
        neschr_wr = 1'b1;
        m2_n = 1'b1;
        cfg_boot = 1'b0;
        cfg_prgmask = 6'b011111;
        cfg_chrmask = 7'h2d;
        cfg_chrram = 1'b1;
        mapper26 = 1'b0;
        build_table();
        limit = 200;
        for (i = 0; i < t_ticks.size(); i++)
            limit += t_ticks[i];
        @(negedge reset);
        @(negedge clk20);
        for (i = 0; i < t_kind.size(); i++) begin
            case (t_kind[i])
                K_WR: begin
                    prgain = t_addr[i];
                    nesprgdin = t_data[i];
                    nesprg_we = 1'b1;
                    @(negedge clk20);
                    nesprg_we = 1'b0;
                    repeat (t_ticks[i] - 1) @(negedge clk20);
                end
                K_PRG, K_OE: begin
                    prgain = t_addr[i];
                    nesprg_we = t_data[i][0];
                    @(posedge clk20);
                    if (t_kind[i] == K_PRG) begin
                        check_prg(t_name[i], t_exp[i], ramprgaout);
                    end else begin
                        check_bit({t_name[i], "_wram_we"}, t_exp[i][2], wram_we);
                        check_bit({t_name[i], "_wram_oe"}, t_exp[i][1], wram_oe);
                        check_bit({t_name[i], "_prgram_oe"}, t_exp[i][0], prgram_oe);
                        check_bit({t_name[i], "_nesprg_oe"}, |t_exp[i][1:0], nesprg_oe);
                    end
                    @(negedge clk20);
                    nesprg_we = 1'b0;
                end
                K_CHR, K_NT: begin
                    chrain = t_addr[i];
                    @(posedge clk20);
                    if (t_kind[i] == K_CHR) begin
                        check_chr(t_name[i], t_exp[i], ramchraout);
                        check_bit({t_name[i], "_ciram_ce"}, 1'b0, ciram_ce);
                        check_bit({t_name[i], "_chrram_oe"}, 1'b1, chrram_oe);
                        check_bit({t_name[i], "_chrram_we"}, 1'b1, chrram_we);
                    end else begin
                        check_bit(t_name[i], t_exp[i], ramchraout[0]);
                        check_bit({t_name[i], "_ciram_ce"}, 1'b1, ciram_ce);
                        check_bit({t_name[i], "_chrram_oe"}, 1'b0, chrram_oe);
                        check_bit({t_name[i], "_chrram_we"}, 1'b0, chrram_we);
                    end
                    @(negedge clk20);
                end
                K_MAP: begin
                    mapper26 = t_data[i];
                    @(negedge clk20);
                end
                K_IRQ: begin
                    repeat (t_ticks[i]) begin
                        @(negedge clk20);
                        check_bit(t_name[i], t_exp[i], irq);
                    end
                end
                K_SND: begin
                    repeat (t_ticks[i]) @(negedge clk20);
                    check_snd(t_name[i], t_exp[i], snd_level[5:0]);
                    check_bit({t_name[i], "_upper"}, 1'b0, |snd_level[15:6]);
                end
                default: begin
                    cnt = 0;
                    peak = 0;
                    repeat (t_ticks[i]) begin
                        @(negedge clk20);
                        if (snd_level != 0)
                            cnt++;
                        if (snd_level > peak)
                            peak = snd_level;
                    end
                    check_snd(t_name[i], t_exp[i], (t_kind[i] == K_DUTY) ? cnt : peak);
                end
            endcase
        end
        if (dut0.chk0.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("ERROR %0d assertion failures in the bound checker", dut0.chk0.fail_count);
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/vrc6_pkg.sv
verilog/vrc6_regs.sv
verilog/vrc6_bank_map.sv
verilog/vrc6_irq.sv
verilog/vrc6_pulse.sv
verilog/vrc6_saw.sv
verilog/vrc6_mapper.sv
test/vrc6_tb_clock.sv
test/vrc6_asserts.sv
test/vrc6_tb.sv
